// ==== hdl/dmaPkg.sv ====
`default_nettype none

package dmaPkg;

	// four channels, two-byte counters
	localparam int numChannels = 4;

	// one register byte on the APB data bus
	typedef logic [7:0] byteT;
	// memory address and word count share one width
	typedef logic [15:0] addrT;
	// channel index
	typedef logic [$clog2(numChannels)-1:0] chanT;
	// one bit per channel for dreq, dack, masks and tc flags
	typedef logic [numChannels-1:0] chanVecT;
	// APB register offset
	typedef logic [3:0] regAddrT;

	// transfer type from the mode register
	// write moves IO to memory, read moves memory to IO
	typedef enum logic [1:0] {
		xferNone  = 2'b00,
		xferWrite = 2'b01,
		xferRead  = 2'b10
	} xferT;

	// 8237 style timing states, no S3 since there are no slow transfers
	typedef enum logic [2:0] {
		SI,
		SO,
		S1,
		S2,
		S4
	} stateT;

	// register map, offsets 0 to 7 are the channel counters
	localparam regAddrT regCmdStatus = 4'd8;
	localparam regAddrT regMode = 4'd11;
	localparam regAddrT regClearFf = 4'd12;

	// command register bit positions
	localparam int cmdDisableBit = 2;
	localparam int cmdRotateBit = 4;

endpackage

`default_nettype wire

// ==== hdl/dmaRegFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmaRegFile
(
	input wire logic busIf,
	input wire logic rstN,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire dmaPkg::regAddrT paddr,
	input wire dmaPkg::byteT pwdata,
	input wire dmaPkg::chanVecT dreq,
	input wire dmaPkg::byteT cntRdByte,
	input wire dmaPkg::chanVecT tcFlagSet,
	input wire dmaPkg::chanT grantCh,
	output dmaPkg::byteT prdata,
	output logic cntWrEn,
	output logic cntRdEn,
	output dmaPkg::regAddrT cntAddr,
	output logic cntHiByte,
	output dmaPkg::byteT cntWrData,
	output dmaPkg::chanVecT eligible,
	output logic rotateMode,
	output dmaPkg::xferT grantType
);

	import dmaPkg::*;

	// enable phase of an access, no wait states
	logic apbWr;
	logic apbRd;
	// offsets 0 to 7 go to the counters
	logic chanSel;
	logic modeWr;
	chanT modeCh;
	chanVecT modeClr;
	// byte pointer flip-flop, 0 selects the low byte
	logic bytePtr;
	// command bits that are kept
	logic disableReg;
	logic rotateReg;
	chanVecT maskReg;
	chanVecT tcFlags;
	chanVecT typeValid;
	xferT modeType [numChannels];

	assign apbWr = psel & penable & pwrite;
	assign apbRd = psel & penable & ~pwrite;
	assign chanSel = (paddr[3] == 1'b0);
	assign modeWr = apbWr && (paddr == regMode);
	// channel number sits in the two low data bits
	assign modeCh = chanT'(pwdata[1:0]);

	// counter access strobes and byte select
	assign cntWrEn = apbWr & chanSel;
	assign cntRdEn = apbRd & chanSel;
	assign cntAddr = paddr;
	assign cntHiByte = bytePtr;
	assign cntWrData = pwdata;

	always_comb
	begin
		modeClr = '0;
		// a mode write unmasks its channel
		if (modeWr)
			modeClr[modeCh] = 1'b1;
	end

	// command register, only disable and rotate are implemented
	always_ff @(posedge busIf)
	begin
		if (!rstN)
		begin
			disableReg <= 1'b0;
			rotateReg <= 1'b0;
		end
		else if (apbWr && (paddr == regCmdStatus))
		begin
			disableReg <= pwdata[cmdDisableBit];
			rotateReg <= pwdata[cmdRotateBit];
		end
	end

	// byte pointer toggles on any counter access, read or write
	always_ff @(posedge busIf)
	begin
		if (!rstN)
			bytePtr <= 1'b0;
		else if (apbWr && (paddr == regClearFf))
			bytePtr <= 1'b0;
		else if (cntWrEn || cntRdEn)
			bytePtr <= ~bytePtr;
	end

	// mode and mask registers
	always_ff @(posedge busIf)
	begin
		if (!rstN)
		begin
			// every channel starts masked and unusable
			maskReg <= '1;
			for (int i = 0; i < numChannels; i++)
				modeType[i] <= xferNone;
		end
		else
		begin
			// terminal count masks the channel until its mode is rewritten
			maskReg <= (maskReg | tcFlagSet) & ~modeClr;
			if (modeWr)
				modeType[modeCh] <= xferT'(pwdata[3:2]);
		end
	end

	// tc flags, cleared by a status read, a new tc still lands
	always_ff @(posedge busIf)
	begin
		if (!rstN)
			tcFlags <= '0;
		else if (apbRd && (paddr == regCmdStatus))
			tcFlags <= tcFlagSet;
		else
			tcFlags <= tcFlags | tcFlagSet;
	end

	always_comb
	begin
		// only read and write types can move data
		for (int i = 0; i < numChannels; i++)
			typeValid[i] = (modeType[i] == xferWrite) || (modeType[i] == xferRead);
	end

	assign eligible = dreq & ~maskReg & typeValid & {numChannels{~disableReg}};
	assign rotateMode = rotateReg;
	assign grantType = modeType[grantCh];

	// read data mux, counters already gate their byte with the read strobe
	always_comb
	begin
		if (chanSel)
			prdata = cntRdByte;
		else if (paddr == regCmdStatus)
			prdata = byteT'({dreq, tcFlags});
		else
			prdata = '0;
	end

endmodule

`default_nettype wire

// ==== hdl/dmaChannelCounters.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmaChannelCounters
(
	input wire logic busIf,
	input wire logic rstN,
	input wire logic cntWrEn,
	input wire logic cntRdEn,
	input wire dmaPkg::regAddrT cntAddr,
	input wire logic cntHiByte,
	input wire dmaPkg::byteT cntWrData,
	input wire logic step,
	input wire dmaPkg::chanT grantCh,
	output dmaPkg::byteT cntRdByte,
	output dmaPkg::addrT addrOut,
	output dmaPkg::chanVecT tcFlagSet
);

	import dmaPkg::*;

	// current address and word count per channel
	addrT curAddr [numChannels];
	addrT curCount [numChannels];
	// channel addressed by the host, offset bits 2:1
	chanT accCh;
	// odd offsets hold the word count
	logic countSel;
	addrT rdWord;
	logic countZero;

	assign accCh = chanT'(cntAddr[2:1]);
	assign countSel = cntAddr[0];

	// readback is combinational, zero outside a read
	assign rdWord = countSel ? curCount[accCh] : curAddr[accCh];
	assign cntRdByte = !cntRdEn ? '0 : (cntHiByte ? rdWord[15:8] : rdWord[7:0]);

	// address bus follows the granted channel
	assign addrOut = curAddr[grantCh];

	// count of zero before the decrement is terminal count
	assign countZero = (curCount[grantCh] == '0);

	always_comb
	begin
		tcFlagSet = '0;
		if (step && countZero)
			tcFlagSet[grantCh] = 1'b1;
	end

	always_ff @(posedge busIf)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < numChannels; i++)
			begin
				curAddr[i] <= '0;
				curCount[i] <= '0;
			end
		end
		else
		begin
			// advance at the end of S4, count wraps past zero
			if (step)
			begin
				curAddr[grantCh] <= curAddr[grantCh] + 1'b1;
				curCount[grantCh] <= curCount[grantCh] - 1'b1;
			end
			// host byte write comes last so it wins over a step
			if (cntWrEn)
			begin
				if (countSel && cntHiByte)
					curCount[accCh][15:8] <= cntWrData;
				else if (countSel)
					curCount[accCh][7:0] <= cntWrData;
				else if (cntHiByte)
					curAddr[accCh][15:8] <= cntWrData;
				else
					curAddr[accCh][7:0] <= cntWrData;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/dmaPriority.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmaPriority
(
	input wire logic busIf,
	input wire logic rstN,
	input wire dmaPkg::chanVecT eligible,
	input wire logic rotateMode,
	input wire logic latchGrant,
	input wire logic serviceDone,
	input wire logic dackEn,
	output logic anyRequest,
	output dmaPkg::chanT grantCh,
	output dmaPkg::chanVecT dack
);

	import dmaPkg::*;

	// channel with highest priority in rotating mode
	chanT rotPtr;
	// search start, channel 0 in fixed mode
	chanT baseCh;
	chanT probeCh;
	chanT pickCh;
	logic found;

	assign anyRequest = |eligible;
	assign baseCh = rotateMode ? rotPtr : '0;

	// first eligible channel walking up from the start, index wraps
	always_comb
	begin
		pickCh = baseCh;
		probeCh = baseCh;
		found = 1'b0;
		for (int i = 0; i < numChannels; i++)
		begin
			probeCh = baseCh + chanT'(i);
			if (!found && eligible[probeCh])
			begin
				pickCh = probeCh;
				found = 1'b1;
			end
		end
	end

	always_ff @(posedge busIf)
	begin
		if (!rstN)
		begin
			grantCh <= '0;
			rotPtr <= '0;
		end
		else
		begin
			// grant held from SO through S4
			if (latchGrant)
				grantCh <= pickCh;
			// served channel drops to lowest priority
			if (serviceDone && rotateMode)
				rotPtr <= grantCh + 1'b1;
		end
	end

	// one-hot acknowledge while the bus is ours
	always_comb
	begin
		dack = '0;
		if (dackEn)
			dack[grantCh] = 1'b1;
	end

endmodule

`default_nettype wire

// ==== hdl/dmaTimingFsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmaTimingFsm
(
	input wire logic busIf,
	input wire logic rstN,
	input wire logic anyRequest,
	input wire logic hlda,
	input wire dmaPkg::xferT grantType,
	output logic hrq,
	output logic aen,
	output logic adstb,
	output logic latchGrant,
	output logic dackEn,
	output logic step,
	output logic serviceDone,
	output logic iorN,
	output logic iowN,
	output logic memrN,
	output logic memwN
);

	import dmaPkg::*;

	stateT state;
	stateT nextState;
	// S2 and S4 carry the read and write strobes
	logic strobeOn;
	logic ioToMem;
	logic memToIo;

	always_comb
	begin
		nextState = state;
		case (state)
			SI:
				if (anyRequest)
					nextState = SO;
			// wait here for the CPU to hand over the bus
			SO:
				if (hlda)
					nextState = S1;
			S1:
				nextState = S2;
			S2:
				nextState = S4;
			S4:
				nextState = SI;
			default:
				nextState = SI;
		endcase
	end

	always_ff @(posedge busIf)
	begin
		if (!rstN)
			state <= SI;
		else
			state <= nextState;
	end

	// hold request stays up until the cycle ends
	assign hrq = (state != SI);
	assign aen = (state == S1) || (state == S2) || (state == S4);
	// address strobe only in S1
	assign adstb = (state == S1);
	assign dackEn = aen;

	// grant taken on the edge that leaves SI
	assign latchGrant = (state == SI) && anyRequest;
	// counters and rotation update on the edge that ends S4
	assign step = (state == S4);
	assign serviceDone = (state == S4);

	assign strobeOn = (state == S2) || (state == S4);
	assign ioToMem = strobeOn && (grantType == xferWrite);
	assign memToIo = strobeOn && (grantType == xferRead);

	// active low strobes
	assign iorN = ~ioToMem;
	assign memwN = ~ioToMem;
	assign memrN = ~memToIo;
	assign iowN = ~memToIo;

endmodule

`default_nettype wire

// ==== hdl/dmaTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmaTop
(
	input wire logic busIf,
	input wire logic rstN,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire dmaPkg::regAddrT paddr,
	input wire dmaPkg::byteT pwdata,
	output wire dmaPkg::byteT prdata,
	input wire dmaPkg::chanVecT dreq,
	input wire logic hlda,
	output wire logic hrq,
	output wire logic aen,
	output wire logic adstb,
	output wire dmaPkg::chanVecT dack,
	output wire dmaPkg::addrT addrOut,
	output wire logic iorN,
	output wire logic iowN,
	output wire logic memrN,
	output wire logic memwN
);

	import dmaPkg::*;

	// regfile to counters
	wire logic cntWrEn;
	wire logic cntRdEn;
	wire regAddrT cntAddr;
	wire logic cntHiByte;
	wire byteT cntWrData;
	wire byteT cntRdByte;
	wire chanVecT tcFlagSet;
	// arbitration
	wire chanVecT eligible;
	wire logic rotateMode;
	wire logic anyRequest;
	wire chanT grantCh;
	wire xferT grantType;
	// timing machine controls
	wire logic latchGrant;
	wire logic dackEn;
	wire logic step;
	wire logic serviceDone;

	dmaRegFile regFile
	(
		.busIf(busIf),
		.rstN(rstN),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.dreq(dreq),
		.cntRdByte(cntRdByte),
		.tcFlagSet(tcFlagSet),
		.grantCh(grantCh),
		.prdata(prdata),
		.cntWrEn(cntWrEn),
		.cntRdEn(cntRdEn),
		.cntAddr(cntAddr),
		.cntHiByte(cntHiByte),
		.cntWrData(cntWrData),
		.eligible(eligible),
		.rotateMode(rotateMode),
		.grantType(grantType)
	);

	dmaChannelCounters counters
	(
		.busIf(busIf),
		.rstN(rstN),
		.cntWrEn(cntWrEn),
		.cntRdEn(cntRdEn),
		.cntAddr(cntAddr),
		.cntHiByte(cntHiByte),
		.cntWrData(cntWrData),
		.step(step),
		.grantCh(grantCh),
		.cntRdByte(cntRdByte),
		.addrOut(addrOut),
		.tcFlagSet(tcFlagSet)
	);

	dmaPriority priorityLogic
	(
		.busIf(busIf),
		.rstN(rstN),
		.eligible(eligible),
		.rotateMode(rotateMode),
		.latchGrant(latchGrant),
		.serviceDone(serviceDone),
		.dackEn(dackEn),
		.anyRequest(anyRequest),
		.grantCh(grantCh),
		.dack(dack)
	);

	dmaTimingFsm timingFsm
	(
		.busIf(busIf),
		.rstN(rstN),
		.anyRequest(anyRequest),
		.hlda(hlda),
		.grantType(grantType),
		.hrq(hrq),
		.aen(aen),
		.adstb(adstb),
		.latchGrant(latchGrant),
		.dackEn(dackEn),
		.step(step),
		.serviceDone(serviceDone),
		.iorN(iorN),
		.iowN(iowN),
		.memrN(memrN),
		.memwN(memwN)
	);

endmodule

`default_nettype wire

// ==== dv/dmaTbTasks.svh ====
`ifndef DMA_TB_TASKS_SVH
`define DMA_TB_TASKS_SVH

// lcg step, middle byte has the better spread
function automatic byteT nextRandom();
	lcgState = lcgState * 32'd1664525 + 32'd1013904223;
	return lcgState[23:16];
endfunction

task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
	checkCount++;
	assert (got === exp)
	else
	begin
		errorCount++;
		$display("CHECK FAILED at %0d ns: %s got %0h expected %0h", $time, what, got, exp);
	end
endtask

task automatic reportTest(input string name, input int startErrors);
	testCount++;
	if (errorCount > startErrors)
	begin
		failedTests++;
		$display("test %s: failed with %0d errors", name, errorCount - startErrors);
	end
	else
		$display("test %s: passed", name);
endtask

// setup, enable, idle, each phase starts on a falling edge
task automatic apbWrite(input regAddrT addr, input byteT data);
	@(negedge busIf);
	psel = 1'b1;
	penable = 1'b0;
	pwrite = 1'b1;
	paddr = addr;
	pwdata = data;
	@(negedge busIf);
	penable = 1'b1;
	@(negedge busIf);
	psel = 1'b0;
	penable = 1'b0;
	pwrite = 1'b0;
endtask

task automatic apbRead(input regAddrT addr, output byteT data);
	@(negedge busIf);
	psel = 1'b1;
	penable = 1'b0;
	pwrite = 1'b0;
	paddr = addr;
	@(negedge busIf);
	penable = 1'b1;
	// sample mid enable phase, before the edge that moves the byte pointer
	#1;
	data = prdata;
	@(negedge busIf);
	psel = 1'b0;
	penable = 1'b0;
endtask

// low byte then high byte for address and count
task automatic programChannel(input chanT ch, input addrT addr, input addrT count);
	apbWrite(regClearFf, 8'h00);
	apbWrite(regAddrT'(2 * ch), addr[7:0]);
	apbWrite(regAddrT'(2 * ch), addr[15:8]);
	apbWrite(regAddrT'(2 * ch + 1), count[7:0]);
	apbWrite(regAddrT'(2 * ch + 1), count[15:8]);
	expAddr[ch] = addr;
	expCount[ch] = count;
endtask

task automatic setMode(input chanT ch, input xferT kind);
	apbWrite(regMode, {4'b0000, kind, ch});
endtask

task automatic expectNoHrq(input int cycles, input string what);
	logic seenHrq;
	seenHrq = 1'b0;
	repeat (cycles)
	begin
		@(negedge busIf);
		if (hrq)
			seenHrq = 1'b1;
	end
	checkValue(what, seenHrq, 1'b0);
endtask

task automatic recordState(input int idx);
	recHrq[idx] = hrq;
	recAen[idx] = aen;
	recAdstb[idx] = adstb;
	recDack[idx] = dack;
	recAddr[idx] = addrOut;
	recStrobe[idx] = {iorN, iowN, memrN, memwN};
endtask

// CPU side of one transfer, releaseReq drops the served dreq on dack
task automatic watchTransfer(input bit releaseReq, output bit seen);
	int waited;
	waited = 0;
	seen = 1'b0;
	@(negedge busIf);
	while (!hrq && waited < hrqWaitLimit)
	begin
		@(negedge busIf);
		waited++;
	end
	if (!hrq)
	begin
		errorCount++;
		$display("error at %0d ns: hrq did not rise within %0d cycles", $time, hrqWaitLimit);
	end
	else
	begin
		// bus handed over one cycle after hrq
		@(negedge busIf);
		recordState(0);
		hlda = 1'b1;
		for (int i = 1; i < 5; i++)
		begin
			@(negedge busIf);
			recordState(i);
			if (i == 1 && releaseReq)
				dreq = dreq & ~dack;
		end
		hlda = 1'b0;
		seen = 1'b1;
	end
endtask

// compare the recorded states with the expected transfer, then step the model
task automatic checkTransfer(input chanT ch, input xferT kind, input string tag);
	logic [3:0] busyStrobes;
	chanVecT oneHot;
	// write type strobes IOR and MEMW, read type MEMR and IOW
	busyStrobes = (kind == xferWrite) ? 4'b0110 : 4'b1001;
	oneHot = chanVecT'(1) << ch;
	checkValue({tag, " hrq in SO"}, recHrq[0], 1'b1);
	checkValue({tag, " aen in SO"}, recAen[0], 1'b0);
	for (int i = 1; i < 4; i++)
	begin
		checkValue($sformatf("%s hrq at step %0d", tag, i), recHrq[i], 1'b1);
		checkValue($sformatf("%s aen at step %0d", tag, i), recAen[i], 1'b1);
		checkValue($sformatf("%s dack at step %0d", tag, i), recDack[i], oneHot);
		checkValue($sformatf("%s address at step %0d", tag, i), recAddr[i], expAddr[ch]);
		checkValue($sformatf("%s strobes at step %0d", tag, i), recStrobe[i],
			(i == 1) ? 4'b1111 : busyStrobes);
	end
	checkValue({tag, " adstb in S1"}, recAdstb[1], 1'b1);
	checkValue({tag, " adstb in S2"}, recAdstb[2], 1'b0);
	checkValue({tag, " hrq after S4"}, recHrq[4], 1'b0);
	checkValue({tag, " dack after S4"}, recDack[4], 4'b0000);
	checkValue({tag, " strobes after S4"}, recStrobe[4], 4'b1111);
	// zero count before the decrement means terminal count
	if (expCount[ch] == '0)
		expTc[ch] = 1'b1;
	expAddr[ch] = expAddr[ch] + 1'b1;
	expCount[ch] = expCount[ch] - 1'b1;
endtask

task automatic registerProgramming();
	int startErrors;
	byteT wr [4];
	byteT rd;
	startErrors = errorCount;
	for (int i = 0; i < 4; i++)
		wr[i] = nextRandom();
	programChannel(2'd0, {wr[1], wr[0]}, {wr[3], wr[2]});
	apbWrite(regClearFf, 8'h00);
	// address low, high, then count low, high
	for (int i = 0; i < 4; i++)
	begin
		apbRead(regAddrT'(i / 2), rd);
		checkValue($sformatf("readback byte %0d", i), rd, wr[i]);
	end
	dreq = '1;
	expectNoHrq(10, "hrq with all channels masked");
	dreq = '0;
	reportTest("register programming", startErrors);
endtask

task automatic singleTransfer();
	int startErrors;
	bit seen;
	byteT lo;
	byteT hi;
	startErrors = errorCount;
	programChannel(2'd1, {nextRandom(), nextRandom()}, {nextRandom() | 8'h01, nextRandom()});
	setMode(2'd1, xferRead);
	dreq = 4'b0010;
	watchTransfer(1'b1, seen);
	if (seen)
		checkTransfer(2'd1, xferRead, "single");
	// address has moved on by one
	apbWrite(regClearFf, 8'h00);
	apbRead(regAddrT'(2), lo);
	apbRead(regAddrT'(2), hi);
	checkValue("address after transfer", {hi, lo}, expAddr[1]);
	reportTest("single transfer", startErrors);
endtask

task automatic fixedPriority();
	int startErrors;
	bit seen;
	startErrors = errorCount;
	for (int ch = 0; ch < numChannels; ch++)
	begin
		programChannel(chanT'(ch), {nextRandom(), nextRandom()},
			{nextRandom() | 8'h40, nextRandom()});
		setMode(chanT'(ch), xferRead);
	end
	dreq = '1;
	// held requests keep channel 0 on top
	for (int n = 0; n < 3; n++)
	begin
		watchTransfer(1'b0, seen);
		if (seen)
			checkTransfer(2'd0, xferRead, "fixed held");
	end
	// each served requester lets go, next index wins
	for (int n = 0; n < numChannels; n++)
	begin
		watchTransfer(1'b1, seen);
		if (seen)
			checkTransfer(chanT'(n), xferRead, "fixed released");
	end
	dreq = '0;
	reportTest("fixed priority", startErrors);
endtask

task automatic rotatingPriority();
	int startErrors;
	bit seen;
	startErrors = errorCount;
	apbWrite(regCmdStatus, byteT'(1 << cmdRotateBit));
	dreq = '1;
	// served channel drops to the bottom, so grants walk upward
	for (int n = 0; n < 5; n++)
	begin
		watchTransfer(1'b0, seen);
		if (seen)
			checkTransfer(chanT'(n % numChannels), xferRead, "rotating");
	end
	dreq = '0;
	apbWrite(regCmdStatus, 8'h00);
	reportTest("rotating priority", startErrors);
endtask

task automatic terminalCount();
	int startErrors;
	bit seen;
	byteT rd;
	startErrors = errorCount;
	apbRead(regCmdStatus, rd);
	checkValue("status before tc", rd, {dreq, expTc});
	expTc = '0;
	programChannel(2'd3, {nextRandom(), nextRandom()}, 16'h0001);
	setMode(2'd3, xferWrite);
	dreq = 4'b1000;
	// count of 1 gives two transfers
	for (int n = 0; n < 2; n++)
	begin
		watchTransfer(1'b0, seen);
		if (seen)
			checkTransfer(2'd3, xferWrite, "tc");
	end
	expectNoHrq(12, "hrq after terminal count");
	apbRead(regCmdStatus, rd);
	checkValue("status with tc", rd, {dreq, expTc});
	expTc = '0;
	apbRead(regCmdStatus, rd);
	checkValue("status after clear", rd, {dreq, expTc});
	// new mode write lifts the automatic mask
	setMode(2'd3, xferWrite);
	watchTransfer(1'b1, seen);
	if (seen)
		checkTransfer(2'd3, xferWrite, "after remode");
	dreq = '0;
	reportTest("terminal count", startErrors);
endtask

task automatic disableControl();
	int startErrors;
	bit seen;
	startErrors = errorCount;
	apbWrite(regCmdStatus, byteT'(1 << cmdDisableBit));
	dreq = 4'b0100;
	expectNoHrq(12, "hrq while disabled");
	apbWrite(regCmdStatus, 8'h00);
	watchTransfer(1'b1, seen);
	if (seen)
		checkTransfer(2'd2, xferRead, "re-enabled");
	dreq = '0;
	reportTest("disable", startErrors);
endtask

`endif

// ==== dv/dmaTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmaTb;

	import dmaPkg::*;

	// whole run takes about 500 cycles, this leaves a wide margin
	localparam int cycleLimit = 3000;
	// longest wait for hrq after a request is posted
	localparam int hrqWaitLimit = 40;

	logic busIf;
	logic rstN;
	logic psel;
	logic penable;
	logic pwrite;
	regAddrT paddr;
	byteT pwdata;
	byteT prdata;
	chanVecT dreq;
	logic hlda;
	logic hrq;
	logic aen;
	logic adstb;
	chanVecT dack;
	addrT addrOut;
	logic iorN;
	logic iowN;
	logic memrN;
	logic memwN;

	// run bookkeeping
	int cycleCount = 0;
	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;
	int failedTests = 0;
	logic [31:0] lcgState;

	// reference model of the channel registers and tc flags
	addrT expAddr [numChannels];
	addrT expCount [numChannels];
	chanVecT expTc;

	// one sample per state of a transfer, SO S1 S2 S4 then SI
	logic recHrq [5];
	logic recAen [5];
	logic recAdstb [5];
	chanVecT recDack [5];
	addrT recAddr [5];
	// strobes packed as iorN iowN memrN memwN
	logic [3:0] recStrobe [5];

	dmaTop UUT
	(
		.busIf(busIf),
		.rstN(rstN),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.dreq(dreq),
		.hlda(hlda),
		.hrq(hrq),
		.aen(aen),
		.adstb(adstb),
		.dack(dack),
		.addrOut(addrOut),
		.iorN(iorN),
		.iowN(iowN),
		.memrN(memrN),
		.memwN(memwN)
	);

	`include "dmaTbTasks.svh"

	// 4 ns period
	always #2 busIf = ~busIf;

	// hard stop if a test never returns
	always @(posedge busIf)
	begin
		cycleCount++;
		if (cycleCount >= cycleLimit)
		begin
			$display("timeout: run stopped after %0d cycles with tests unfinished", cycleCount);
			$display(">>> FAIL");
			$finish;
		end
	end

	initial
	begin
		busIf = 1'b0;
		rstN = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		dreq = '0;
		hlda = 1'b0;
		expTc = '0;
		lcgState = 32'd76;
		// reset held for 16 cycles, released on a falling edge
		repeat (16) @(posedge busIf);
		@(negedge busIf);
		rstN = 1'b1;

		registerProgramming();
		singleTransfer();
		fixedPriority();
		rotatingPriority();
		terminalCount();
		disableControl();

		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
			testCount, failedTests, checkCount, errorCount);
		if (errorCount == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+dv
hdl/dmaPkg.sv
hdl/dmaRegFile.sv
hdl/dmaChannelCounters.sv
hdl/dmaPriority.sv
hdl/dmaTimingFsm.sv
hdl/dmaTop.sv
dv/dmaTb.sv
